/* design/ahb_apb_bridge.sv */
`timescale 1ns/1ps

`include "ahb_apb_macros.svh"

module ahb_apb_bridge (
  input  logic                    hclk,
  input  logic                    hreset_n,
  input  logic                    hsel,
  input  ahb_apb_pkg::addr_t      haddr,
  input  ahb_apb_pkg::htrans_e    htrans,
  input  logic                    hwrite,
  input  ahb_apb_pkg::data_t      hwdata,
  output logic                    hready,
  output ahb_apb_pkg::data_t      hrdata,
  output ahb_apb_pkg::hresp_t     hresp,
  output ahb_apb_pkg::addr_t      paddr,
  output logic                    pwrite,
  output logic                    penable,
  output ahb_apb_pkg::data_t      pwdata,
  output ahb_apb_pkg::slave_vec_t psel,
  input  ahb_apb_pkg::slave_vec_t pready,
  input  ahb_apb_pkg::data_t      prdata [`AHB_APB_NUM_SLAVES]
);

  logic                    xfer_start;
  logic                    xfer_pending;
  ahb_apb_pkg::addr_t      xfer_addr;
  logic                    xfer_write;
  logic                    xfer_done;
  ahb_apb_pkg::data_t      xfer_rdata;
  logic                    sel_load;
  logic                    sel_clear;
  ahb_apb_pkg::slave_vec_t slot_pready;
  ahb_apb_pkg::data_t      slot_prdata [`AHB_APB_NUM_SLAVES];

  // Always OKAY, master keeps hwdata stable while stalled
  assign hresp  = 2'b00;
  assign pwdata = hwdata;

  ahb_slave_if u_ahb_slave_if (
    .hclk         (hclk),
    .hreset_n     (hreset_n),
    .hsel         (hsel),
    .haddr        (haddr),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .hready       (hready),
    .hrdata       (hrdata),
    .xfer_start   (xfer_start),
    .xfer_pending (xfer_pending),
    .xfer_addr    (xfer_addr),
    .xfer_write   (xfer_write),
    .xfer_done    (xfer_done),
    .xfer_rdata   (xfer_rdata)
  );

  // --------------------------------------------------
  // One slot per APB slave, laid out back to back
  // --------------------------------------------------

  for (genvar i = 0; i < `AHB_APB_NUM_SLAVES; i++) begin : g_slot
    apb_slot #(
      .slot_start (ahb_apb_pkg::addr_t'(`AHB_APB_SLOT_BASE + i * `AHB_APB_SLOT_SPAN)),
      .slot_end   (ahb_apb_pkg::addr_t'(`AHB_APB_SLOT_BASE + (i + 1) * `AHB_APB_SLOT_SPAN - 1))
    ) u_apb_slot (
      .hclk        (hclk),
      .hreset_n    (hreset_n),
      .haddr       (haddr),
      .xfer_start  (xfer_start),
      .sel_load    (sel_load),
      .sel_clear   (sel_clear),
      .psel        (psel[i]),
      .pready      (pready[i]),
      .prdata      (prdata[i]),
      .slot_pready (slot_pready[i]),
      .slot_prdata (slot_prdata[i])
    );
  end

  apb_sequencer u_apb_sequencer (
    .hclk         (hclk),
    .hreset_n     (hreset_n),
    .xfer_pending (xfer_pending),
    .xfer_addr    (xfer_addr),
    .xfer_write   (xfer_write),
    .slot_pready  (slot_pready),
    .slot_prdata  (slot_prdata),
    .sel_load     (sel_load),
    .sel_clear    (sel_clear),
    .paddr        (paddr),
    .pwrite       (pwrite),
    .penable      (penable),
    .xfer_done    (xfer_done),
    .xfer_rdata   (xfer_rdata)
  );

endmodule

/* design/ahb_apb_macros.svh */
`ifndef AHB_APB_MACROS_SVH
`define AHB_APB_MACROS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------

`define AHB_APB_ADDR_W 32
`define AHB_APB_DATA_W 32

// --------------------------------------------------
// APB slave map
// --------------------------------------------------

// Any count from 1 to 16 fits in the map below
`define AHB_APB_NUM_SLAVES 4

// Slot 0 starts here, slot i at base + i * span
`define AHB_APB_SLOT_BASE 32'h1000_0000

// 4 KB per slot, last byte one below the next slot
`define AHB_APB_SLOT_SPAN 32'h0000_1000

`endif

/* design/ahb_apb_pkg.sv */
`include "ahb_apb_macros.svh"

package ahb_apb_pkg;

  // Plain vectors for bus fields
  typedef logic [`AHB_APB_ADDR_W-1:0]     addr_t;
  typedef logic [`AHB_APB_DATA_W-1:0]     data_t;
  typedef logic [`AHB_APB_NUM_SLAVES-1:0] slave_vec_t;
  typedef logic [1:0]                     hresp_t;

  // AHB transfer type encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // One-hot APB sequencer states
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_e;

endpackage

/* design/ahb_slave_if.sv */
`timescale 1ns/1ps

`include "ahb_apb_macros.svh"

module ahb_slave_if (
  input  logic                 hclk,
  input  logic                 hreset_n,
  input  logic                 hsel,
  input  ahb_apb_pkg::addr_t   haddr,
  input  ahb_apb_pkg::htrans_e htrans,
  input  logic                 hwrite,
  output logic                 hready,
  output ahb_apb_pkg::data_t   hrdata,
  output logic                 xfer_start,
  output logic                 xfer_pending,
  output ahb_apb_pkg::addr_t   xfer_addr,
  output logic                 xfer_write,
  input  logic                 xfer_done,
  input  ahb_apb_pkg::data_t   xfer_rdata
);

  logic valid_trans;
  logic xfer_end;

  // Only NONSEQ and SEQ to this slave start a transfer
  assign valid_trans = hsel && ((htrans == ahb_apb_pkg::NONSEQ) ||
                                (htrans == ahb_apb_pkg::SEQ));

  // Accept in the address phase while the bridge is free
  assign xfer_start = hready && valid_trans;
  assign xfer_end   = xfer_pending && xfer_done;

  // --------------------------------------------------
  // Address/data phase tracking
  // --------------------------------------------------

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      hready       <= 1'b1;
      xfer_pending <= 1'b0;
    end else if (xfer_start) begin
      hready       <= 1'b0;
      xfer_pending <= 1'b1;
    end else if (xfer_end) begin
      hready       <= 1'b1;
      xfer_pending <= 1'b0;
    end
  end

  // Captured address phase and returned read data
  always_ff @(posedge hclk) begin
    if (xfer_start) begin
      xfer_addr  <= haddr;
      xfer_write <= hwrite;
    end
    if (xfer_end && !xfer_write) begin
      hrdata <= xfer_rdata;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Data phase always stalls the master
  property p_phase_exclusive;
    @(posedge hclk) disable iff (!hreset_n)
      !(hready && xfer_pending);
  endproperty

  a_phase_exclusive: assert property (p_phase_exclusive)
    else $error("hready is high while an AHB data phase is pending");

endmodule

/* design/apb_sequencer.sv */
`timescale 1ns/1ps

`include "ahb_apb_macros.svh"

module apb_sequencer (
  input  logic                    hclk,
  input  logic                    hreset_n,
  input  logic                    xfer_pending,
  input  ahb_apb_pkg::addr_t      xfer_addr,
  input  logic                    xfer_write,
  input  ahb_apb_pkg::slave_vec_t slot_pready,
  input  ahb_apb_pkg::data_t      slot_prdata [`AHB_APB_NUM_SLAVES],
  output logic                    sel_load,
  output logic                    sel_clear,
  output ahb_apb_pkg::addr_t      paddr,
  output logic                    pwrite,
  output logic                    penable,
  output logic                    xfer_done,
  output ahb_apb_pkg::data_t      xfer_rdata
);

  // Longest ACCESS phase tolerated before a slot is considered missing
  localparam int unsigned access_limit = 16;

  ahb_apb_pkg::apb_state_e apb_state;
  logic                    pready_any;

  // --------------------------------------------------
  // Response merge
  // --------------------------------------------------

  // Slots gate their own response, so a plain OR selects
  assign pready_any = |slot_pready;

  always_comb begin
    xfer_rdata = '0;
    for (int i = 0; i < `AHB_APB_NUM_SLAVES; i++) begin
      xfer_rdata = xfer_rdata | slot_prdata[i];
    end
  end

  // Strobes to the slots and the AHB front end
  assign sel_load  = (apb_state == ahb_apb_pkg::APB_IDLE) && xfer_pending;
  assign xfer_done = (apb_state == ahb_apb_pkg::APB_ACCESS) && pready_any;
  assign sel_clear = xfer_done;

  // --------------------------------------------------
  // IDLE -> SETUP -> ACCESS -> IDLE
  // --------------------------------------------------

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      apb_state <= ahb_apb_pkg::APB_IDLE;
      penable   <= 1'b0;
      pwrite    <= 1'b0;
    end else begin
      case (apb_state)
        ahb_apb_pkg::APB_IDLE: begin
          if (sel_load) begin
            apb_state <= ahb_apb_pkg::APB_SETUP;
            pwrite    <= xfer_write;
          end
        end
        ahb_apb_pkg::APB_SETUP: begin
          apb_state <= ahb_apb_pkg::APB_ACCESS;
          penable   <= 1'b1;
        end
        ahb_apb_pkg::APB_ACCESS: begin
          // Wait states hold everything
          if (xfer_done) begin
            apb_state <= ahb_apb_pkg::APB_IDLE;
            penable   <= 1'b0;
          end
        end
        default: begin
          apb_state <= ahb_apb_pkg::APB_IDLE;
          penable   <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge hclk) begin
    if (sel_load) begin
      paddr <= xfer_addr;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  property p_penable_access;
    @(posedge hclk) disable iff (!hreset_n)
      penable |-> (apb_state == ahb_apb_pkg::APB_ACCESS);
  endproperty

  a_penable_access: assert property (p_penable_access)
    else $error("penable is high outside the ACCESS state");

  // No selected slot means no pready ever comes back
  property p_slot_selected;
    @(posedge hclk) disable iff (!hreset_n)
      (apb_state == ahb_apb_pkg::APB_SETUP) |=> ##[0:access_limit] pready_any;
  endproperty

  a_slot_selected: assert property (p_slot_selected)
    else $error("APB transfer got no pready, the address is outside every slave slot");

endmodule

/* design/apb_slot.sv */
`timescale 1ns/1ps

`include "ahb_apb_macros.svh"

module apb_slot #(
  parameter ahb_apb_pkg::addr_t slot_start = `AHB_APB_SLOT_BASE,
  parameter ahb_apb_pkg::addr_t slot_end   = `AHB_APB_SLOT_BASE + `AHB_APB_SLOT_SPAN - 1
) (
  input  logic               hclk,
  input  logic               hreset_n,
  input  ahb_apb_pkg::addr_t haddr,
  input  logic               xfer_start,
  input  logic               sel_load,
  input  logic               sel_clear,
  output logic               psel,
  input  logic               pready,
  input  ahb_apb_pkg::data_t prdata,
  output logic               slot_pready,
  output ahb_apb_pkg::data_t slot_prdata
);

  logic hit;

  // Range compare on the accepted address phase
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      hit <= 1'b0;
    end else if (xfer_start) begin
      hit <= (haddr >= slot_start) && (haddr <= slot_end);
    end
  end

  // psel follows the hit in SETUP, drops when ACCESS completes
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      psel <= 1'b0;
    end else if (sel_clear) begin
      psel <= 1'b0;
    end else if (sel_load) begin
      psel <= hit;
    end
  end

  // Unselected slots contribute zero to the OR merge
  assign slot_pready = psel & pready;
  assign slot_prdata = psel ? prdata : '0;

  // Select only comes from the sequencer's SETUP entry
  property p_psel_from_load;
    @(posedge hclk) disable iff (!hreset_n)
      $rose(psel) |-> $past(sel_load);
  endproperty

  a_psel_from_load: assert property (p_psel_from_load)
    else $error("psel rose without a sel_load from the sequencer");

endmodule

/* run_sim.sh */
#!/bin/bash
# Build and run the AHB-to-APB bridge testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_ahb_apb_bridge \
  --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi

/* sources.f */
+incdir+design
design/ahb_apb_pkg.sv
design/ahb_slave_if.sv
design/apb_slot.sv
design/apb_sequencer.sv
design/ahb_apb_bridge.sv
test/tb_apb_memory.sv
test/tb_ahb_apb_bridge.sv

/* test/tb_ahb_apb_bridge.sv */
`timescale 1ns/1ps

`include "ahb_apb_macros.svh"

module tb_ahb_apb_bridge;

  localparam int num_slaves  = `AHB_APB_NUM_SLAVES;
  localparam int ready_limit = 40;

  logic                    hclk;
  logic                    hreset_n;
  logic                    hsel;
  ahb_apb_pkg::addr_t      haddr;
  ahb_apb_pkg::htrans_e    htrans;
  logic                    hwrite;
  ahb_apb_pkg::data_t      hwdata;
  logic                    hready;
  ahb_apb_pkg::data_t      hrdata;
  ahb_apb_pkg::hresp_t     hresp;
  ahb_apb_pkg::addr_t      paddr;
  logic                    pwrite;
  logic                    penable;
  ahb_apb_pkg::data_t      pwdata;
  ahb_apb_pkg::slave_vec_t psel;
  ahb_apb_pkg::slave_vec_t pready;
  ahb_apb_pkg::data_t      prdata [num_slaves];
  int                      last_waits;

  // Current transfer expectations and the memory mirror
  ahb_apb_pkg::addr_t      exp_addr;
  logic                    exp_write;
  ahb_apb_pkg::slave_vec_t exp_sel;
  ahb_apb_pkg::data_t      exp_wdata;
  ahb_apb_pkg::data_t      exp_rdata;
  ahb_apb_pkg::data_t      sb [num_slaves][16];
  int                      low_cycles;
  int                      errors;
  int                      timeouts;
  integer                  seed;

  ahb_apb_bridge dut0 (
    .hclk (hclk), .hreset_n (hreset_n), .hsel (hsel), .haddr (haddr), .htrans (htrans),
    .hwrite (hwrite), .hwdata (hwdata), .hready (hready), .hrdata (hrdata), .hresp (hresp),
    .paddr (paddr), .pwrite (pwrite), .penable (penable), .pwdata (pwdata), .psel (psel),
    .pready (pready), .prdata (prdata)
  );

  tb_apb_memory apb_mem0 (
    .hclk (hclk), .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .pready (pready), .prdata (prdata), .last_waits (last_waits)
  );

  always #50 hclk = ~hclk;

  // Length of the current stall in cycles
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n || hready) begin
      low_cycles <= 0;
    end else begin
      low_cycles <= low_cycles + 1;
    end
  end

  function automatic void record_error(input string msg);
    errors++;
    $display("ERR at %0t ns: %s", $time, msg);
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  a_reset_values: assert property (@(posedge hclk) $rose(hreset_n) |->
    hready && !penable && (psel == '0)) else record_error("reset values wrong");
  a_sel_match: assert property (@(posedge hclk) disable iff (!hreset_n) (|psel) |->
    psel == exp_sel && paddr == exp_addr && pwrite == exp_write)
    else record_error("psel, paddr or pwrite differ from the accepted transfer");
  a_enable_rise: assert property (@(posedge hclk) disable iff (!hreset_n)
    $rose(|psel) |-> !penable ##1 penable) else record_error("penable not one cycle after psel");
  a_enable_drop: assert property (@(posedge hclk) disable iff (!hreset_n)
    (penable && |(psel & pready)) |=> !penable && psel == '0)
    else record_error("penable and psel did not drop after pready");
  a_ready_length: assert property (@(posedge hclk) disable iff (!hreset_n)
    $rose(hready) |-> low_cycles == 3 + last_waits) else record_error("hready low time wrong");
  a_read_data: assert property (@(posedge hclk) disable iff (!hreset_n)
    ($rose(hready) && !exp_write) |-> hrdata == exp_rdata) else record_error("hrdata mismatch");
  a_write_data: assert property (@(posedge hclk) disable iff (!hreset_n)
    (|psel && pwrite) |-> pwdata == exp_wdata) else record_error("pwdata mismatch");
  a_no_request: assert property (@(posedge hclk) disable iff (!hreset_n)
    (hready && !(hsel && (htrans == ahb_apb_pkg::NONSEQ || htrans == ahb_apb_pkg::SEQ)))
    |=> hready && psel == '0) else record_error("bridge reacted without a valid request");
  a_okay: assert property (@(posedge hclk) disable iff (!hreset_n) hresp == 2'b00)
    else record_error("hresp not OKAY");

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  task automatic run_transfer(input logic write, input int slot, input int word,
                              input ahb_apb_pkg::data_t wdata);
    int cycles;
    exp_addr  = ahb_apb_pkg::addr_t'(`AHB_APB_SLOT_BASE + slot * `AHB_APB_SLOT_SPAN + word * 4);
    exp_write = write;
    exp_sel   = ahb_apb_pkg::slave_vec_t'(1) << slot;
    exp_wdata = wdata;
    exp_rdata = sb[slot][word];
    hsel      = 1'b1;
    haddr     = exp_addr;
    htrans    = ahb_apb_pkg::NONSEQ;
    hwrite    = write;
    // hready is high here, so this edge accepts
    @(posedge hclk);
    #1;
    hsel   = 1'b0;
    htrans = ahb_apb_pkg::IDLE;
    hwdata = wdata;
    cycles = 0;
    while (!hready && cycles < ready_limit) begin
      @(posedge hclk);
      #1;
      cycles++;
    end
    if (!hready) begin
      timeouts++;
      $display("Timeout at %0t ns: hready stayed low for %0d cycles", $time, ready_limit);
    end else if (write) begin
      sb[slot][word] = wdata;
    end
    // Quiet cycle so the response checks still see this transfer
    @(posedge hclk);
    #1;
  endtask

  // Kind 0 deselected NONSEQ, 1 selected IDLE, 2 selected BUSY
  task automatic insert_idle(input int kind, input int cycles);
    hsel  = (kind != 0);
    haddr = ahb_apb_pkg::addr_t'(`AHB_APB_SLOT_BASE);
    case (kind)
      0:       htrans = ahb_apb_pkg::NONSEQ;
      2:       htrans = ahb_apb_pkg::BUSY;
      default: htrans = ahb_apb_pkg::IDLE;
    endcase
    repeat (cycles) begin
      @(posedge hclk);
      #1;
    end
    hsel   = 1'b0;
    htrans = ahb_apb_pkg::IDLE;
  endtask

  initial begin
    hclk      = 1'b0;
    hreset_n  = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = ahb_apb_pkg::IDLE;
    hwrite    = 1'b0;
    hwdata    = '0;
    exp_addr  = '0;
    exp_write = 1'b0;
    exp_sel   = '0;
    exp_wdata = '0;
    exp_rdata = '0;
    errors    = 0;
    timeouts  = 0;
    seed      = 32'h589d_2e5a;
    repeat (16) @(posedge hclk);
    #1;
    hreset_n = 1'b1;
    @(posedge hclk);
    #1;
    // Write every word once to fill the scoreboard
    for (int s = 0; s < num_slaves && timeouts == 0; s++) begin
      for (int w = 0; w < 16 && timeouts == 0; w++) begin
        run_transfer(1'b1, s, w, ahb_apb_pkg::data_t'($random(seed)));
      end
    end
    // Mixed reads and writes rotating over the slots
    for (int i = 0; i < 48 && timeouts == 0; i++) begin
      insert_idle(int'($unsigned($random(seed)) % 3), int'($unsigned($random(seed)) % 3));
      run_transfer(($unsigned($random(seed)) % 2) == 1, i % num_slaves,
                   int'($unsigned($random(seed)) % 16), ahb_apb_pkg::data_t'($random(seed)));
    end
    repeat (4) @(posedge hclk);
    $display("Check summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/tb_apb_memory.sv */
`timescale 1ns/1ps

`include "ahb_apb_macros.svh"

module tb_apb_memory (
  input  logic                    hclk,
  input  ahb_apb_pkg::slave_vec_t psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  ahb_apb_pkg::addr_t      paddr,
  input  ahb_apb_pkg::data_t      pwdata,
  output ahb_apb_pkg::slave_vec_t pready,
  output ahb_apb_pkg::data_t      prdata [`AHB_APB_NUM_SLAVES],
  output int                      last_waits
);

  ahb_apb_pkg::data_t mem [`AHB_APB_NUM_SLAVES][16];
  int                 waits_left [`AHB_APB_NUM_SLAVES];
  logic               busy [`AHB_APB_NUM_SLAVES];
  integer             seed;

  initial begin
    seed       = 32'h589d_2e5a;
    last_waits = 0;
    for (int s = 0; s < `AHB_APB_NUM_SLAVES; s++) begin
      pready[s]     = 1'b0;
      prdata[s]     = '0;
      busy[s]       = 1'b0;
      waits_left[s] = 0;
      // Fill follows the full byte address
      for (int w = 0; w < 16; w++) begin
        mem[s][w] = ahb_apb_pkg::data_t'(`AHB_APB_SLOT_BASE + s * `AHB_APB_SLOT_SPAN + w * 4)
                    ^ 32'h6c3a_95f0;
      end
    end
  end

  // --------------------------------------------------
  // APB responder, decisions on values seen at the edge
  // --------------------------------------------------

  always begin
    @(posedge hclk);
    for (int s = 0; s < `AHB_APB_NUM_SLAVES; s++) begin
      if (psel[s] && !penable) begin
        // SETUP seen, pick 0 to 3 wait states
        busy[s]       = 1'b1;
        waits_left[s] = int'($unsigned($random(seed)) % 4);
        last_waits    = waits_left[s];
      end else if (psel[s] && pready[s]) begin
        busy[s] = 1'b0;
        if (pwrite) begin
          mem[s][paddr[5:2]] = pwdata;
        end
      end else if (busy[s]) begin
        waits_left[s] = waits_left[s] - 1;
      end
    end
    #1;
    for (int s = 0; s < `AHB_APB_NUM_SLAVES; s++) begin
      pready[s] = busy[s] && (waits_left[s] == 0);
      prdata[s] = pready[s] ? mem[s][paddr[5:2]] : '0;
    end
  end

endmodule
